//--- testbench/apb_soc_ctrl_golden.txt
# op name arg value, numbers in hex; W addr wdata, R addr expected, M/C pad expected
# S cycles side {jtag_in[15:8], valid[4], fetch_en[3], fll_clk[2], bootsel[1:0]}; K group expected
R reset_info 000 00040001
R reset_fcboot 004 1A000080
R reset_cluster_ctrl 070 00000009
R reset_padcfg0 020 3F3F3F3F
R reset_padcfg1 024 3F3F3F3F
R reset_padcfg2 028 3F3F3F3F
R reset_padcfg3 02C 3F3F3F3F
R reset_padcfg4 030 3F3F3F3F
R reset_padcfg5 034 3F3F3F3F
R reset_padcfg6 038 3F3F3F3F
R reset_padcfg7 03C 3F3F3F3F
R reset_padcfg8 040 3F3F3F3F
R reset_padcfg9 044 3F3F3F3F
R reset_padcfg10 048 3F3F3F3F
R reset_padcfg11 04C 3F3F3F3F
R reset_padcfg12 050 3F3F3F3F
R reset_padcfg13 054 3F3F3F3F
R reset_padcfg14 058 3F3F3F3F
R reset_padcfg15 05C 3F3F3F3F
K reset_ctrl_bits 0 00000009
K reset_cluster_boot_lo 1 00000000
K reset_cluster_boot_hi 2 00000000
K reset_fc_bootaddr 3 1A000080
K reset_jtag_out 4 00000000
M reset_pad0_mux 0 0
C reset_pad63_cfg 3F 3F
W padfun2_write 018 9C63E41B
R padfun2_read 018 9C63E41B
M pad32_mux 20 3
M pad33_mux 21 2
M pad39_mux 27 3
M pad47_mux 2F 2
M pad48_mux 30 0
W padcfg5_write 034 FFC0A5FF
R padcfg5_read 034 3F00253F
C pad20_cfg 14 3F
C pad21_cfg 15 25
C pad22_cfg 16 00
C pad23_cfg 17 3F
C pad24_cfg 18 3F
W cluster_ctrl_write 070 00000006
W cluster_irq_write 07C 00000001
W cluster_boot_lo_write 080 12345678
W cluster_boot_hi_write 084 9ABCDEF0
R cluster_ctrl_read 070 00000006
R cluster_irq_read 07C 00000001
R cluster_boot_lo_read 080 12345678
R cluster_boot_hi_read 084 9ABCDEF0
K cluster_ctrl_bits 0 00000016
K cluster_boot_lo 1 12345678
K cluster_boot_hi 2 9ABCDEF0
W unmapped_write 00C FFFFFFFF
R unmapped_read 00C 00000000
K unmapped_no_effect 0 00000016
R unmapped_cluster_ctrl 070 00000006
W corestatus_write 0A0 80000123
R cs_ro_mirror 0C0 80000123
W cs_ro_write 0C0 00000000
R cs_ro_unchanged 0C0 80000123
R corestatus_read 0A0 80000123
S bootsel_set 1 00000002
R bootsel_read 0C4 00000002
S fll_clk_on 1 00000006
R clksel_on 0C8 00000001
S fll_clk_off 1 00000002
R clksel_off 0C8 00000000
W jtag_out_write 074 000000C3
S jtag_in_set 2 00005A02
R jtag_read 074 00005AC3
K jtag_out_pin 4 000000C3
W fcboot_write 004 1C008000
R fcboot_read 004 1C008000
K fc_bootaddr_pin 3 1C008000
W fcfetch_write 008 00000001
R fcfetch_reads_zero 008 00000000
K fetchen_set 0 00000036
S fetch_en_pulse 1 00005A12
S fetch_en_release 1 00005A02
K fetchen_cleared 0 00000016

//--- sources.f
+incdir+source
source/soc_ctrl_pkg.sv
source/pad_ctrl_regs.sv
source/boot_status_regs.sv
source/cluster_ctrl_regs.sv
source/jtag_mailbox.sv
source/apb_soc_ctrl.sv
testbench/tb_apb_soc_ctrl.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_apb_soc_ctrl -o sim_apb_soc_ctrl

out=$(./obj_dir/sim_apb_soc_ctrl)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx 'All tests passed!'

//--- testbench/tb_apb_soc_ctrl.sv
`timescale 1ns/1ps
`include "soc_ctrl_consts.svh"

module tb_apb_soc_ctrl;

   localparam int MAX_WAIT = 16;  // negedges allowed for PREADY
   localparam int MAX_IDLE = 64;  // longest idle stretch a golden line may ask for

   logic                                   HCLK;
   logic                                   HRESETn;
   soc_ctrl_pkg::apb_addr_t                paddr;
   soc_ctrl_pkg::reg_word_t                pwdata;
   logic                                   pwrite;
   logic                                   psel;
   logic                                   penable;
   soc_ctrl_pkg::reg_word_t                prdata;
   logic                                   pready;
   logic                                   pslverr;
   logic                                   sel_fll_clk;
   logic [1:0]                             bootsel;
   logic                                   fc_fetch_en_valid;
   logic                                   fc_fetch_en;
   soc_ctrl_pkg::jtag_word_t               jtag_in;
   soc_ctrl_pkg::jtag_word_t               jtag_out;
   soc_ctrl_pkg::pad_cfg_t [`NUM_PADS-1:0] pad_cfg;
   soc_ctrl_pkg::pad_fun_t [`NUM_PADS-1:0] pad_mux;
   soc_ctrl_pkg::reg_word_t                fc_bootaddr;
   logic                                   fc_fetchen;
   logic                                   cluster_pow;
   logic                                   cluster_byp;
   logic                                   cluster_fetch_enable;
   logic                                   cluster_rstn;
   logic                                   cluster_irq;
   logic [63:0]                            cluster_boot_addr;

   int               tests_run;
   int               tests_failed;
   int               errors;
   int               fd;
   int               code;
   bit               timed_out;
   bit               done;
   logic [7:0]       op;
   logic [8*32-1:0]  test_name;
   logic [31:0]      arg;
   logic [31:0]      value;
   logic [8*160-1:0] skip_line;

   apb_soc_ctrl dut_i
   (
      .HCLK                   (HCLK),
      .HRESETn                (HRESETn),
      .paddr_i                (paddr),
      .pwdata_i               (pwdata),
      .pwrite_i               (pwrite),
      .psel_i                 (psel),
      .penable_i              (penable),
      .prdata_o               (prdata),
      .pready_o               (pready),
      .pslverr_o              (pslverr),
      .sel_fll_clk_i          (sel_fll_clk),
      .bootsel_i              (bootsel),
      .fc_fetch_en_valid_i    (fc_fetch_en_valid),
      .fc_fetch_en_i          (fc_fetch_en),
      .soc_jtag_reg_i         (jtag_in),
      .pad_cfg_o              (pad_cfg),
      .pad_mux_o              (pad_mux),
      .soc_jtag_reg_o         (jtag_out),
      .fc_bootaddr_o          (fc_bootaddr),
      .fc_fetchen_o           (fc_fetchen),
      .cluster_pow_o          (cluster_pow),
      .cluster_byp_o          (cluster_byp),
      .cluster_boot_addr_o    (cluster_boot_addr),
      .cluster_fetch_enable_o (cluster_fetch_enable),
      .cluster_rstn_o         (cluster_rstn),
      .cluster_irq_o          (cluster_irq)
   );

   initial
   begin
      HCLK = 1'b0;
      forever #4 HCLK = ~HCLK;  // 8 ns period
   end

   task automatic report_mismatch(input logic [31:0] expected, input logic [31:0] actual);
      $display("MISMATCH %0s expected %08h actual %08h", test_name, expected, actual);
      errors++;
   endtask

   // setup cycle, access cycle, then back to idle one edge later
   task automatic apb_access(input logic write, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rd);
      int waits;
      waits   = 0;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr[`APB_ADDR_WIDTH-1:0];
      pwdata  = wdata;
      @(posedge HCLK);
      #1;
      penable = 1'b1;
      @(negedge HCLK);  // mid access phase, prdata settled
      while (pready !== 1'b1 && waits < MAX_WAIT)
      begin
         @(negedge HCLK);
         waits++;
      end
      if (pready !== 1'b1)
      begin
         $display("timeout: PREADY stayed low for %0d cycles in %0s", MAX_WAIT, test_name);
         timed_out = 1'b1;
         errors++;
      end
      if (pslverr !== 1'b0)
      begin
         $display("error response: PSLVERR was raised in %0s", test_name);
         errors++;
      end
      rd = prdata;
      @(posedge HCLK);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic set_side_inputs(input logic [31:0] side);
      bootsel           = side[1:0];
      sel_fll_clk       = side[2];
      fc_fetch_en       = side[3];
      fc_fetch_en_valid = side[4];
      jtag_in           = side[15:8];
   endtask

   function automatic logic [31:0] observe_outputs(input logic [31:0] sel);
      logic [31:0] word;
      case (sel)
         32'd0:   word = {26'h0, fc_fetchen, cluster_irq, cluster_rstn,
                          cluster_fetch_enable, cluster_pow, cluster_byp};
         32'd1:   word = cluster_boot_addr[31:0];
         32'd2:   word = cluster_boot_addr[63:32];
         32'd3:   word = fc_bootaddr;
         32'd4:   word = {24'h0, jtag_out};
         default: word = 32'h0;
      endcase
      return word;
   endfunction

   task automatic run_golden_line();
      int          errors_before;
      logic [31:0] rdata;
      logic [5:0]  pad;
      errors_before = errors;
      pad           = arg[5:0];
      tests_run++;
      case (op)
         "W": apb_access(1'b1, arg, value, rdata);
         "R":
         begin
            apb_access(1'b0, arg, 32'h0, rdata);
            if (rdata !== value)
               report_mismatch(value, rdata);
         end
         "M":
         begin
            if ({30'h0, pad_mux[pad]} !== value)
               report_mismatch(value, {30'h0, pad_mux[pad]});
         end
         "C":
         begin
            if ({26'h0, pad_cfg[pad]} !== value)
               report_mismatch(value, {26'h0, pad_cfg[pad]});
         end
         "S":
         begin
            set_side_inputs(value);
            if (arg > 32'(MAX_IDLE))
            begin
               $display("golden line %0s asks for more idle cycles than allowed", test_name);
               errors++;
            end
            else
               for (int n = 0; n < int'(arg); n++)
               begin
                  @(posedge HCLK);
                  #1;
               end
         end
         "K":
         begin
            if (arg > 32'd4)
            begin
               $display("golden line %0s names an unknown output group", test_name);
               errors++;
            end
            else if (observe_outputs(arg) !== value)
               report_mismatch(value, observe_outputs(arg));
         end
         default:
         begin
            $display("golden line %0s has an unknown operation letter", test_name);
            errors++;
         end
      endcase
      if (errors == errors_before)
         $display("ok   %0s", test_name);
      else
      begin
         $display("fail %0s", test_name);
         tests_failed++;
      end
   endtask

   initial
   begin
      HRESETn      = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      pwrite       = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      set_side_inputs(32'h0);
      tests_run    = 0;
      tests_failed = 0;
      errors       = 0;
      timed_out    = 1'b0;
      done         = 1'b0;
      fd = $fopen("testbench/apb_soc_ctrl_golden.txt", "r");
      if (fd == 0)
      begin
         $display("could not open testbench/apb_soc_ctrl_golden.txt");
         errors++;
         done = 1'b1;
      end
      repeat (8) @(posedge HCLK);
      #1;
      HRESETn = 1'b1;
      while (!done)
      begin
         code = $fscanf(fd, "%s", op);
         if (code != 1)
            done = 1'b1;  // end of file
         else if (op == "#")
            code = $fgets(skip_line, fd);
         else
         begin
            code = $fscanf(fd, "%s %h %h", test_name, arg, value);
            if (code != 3)
            begin
               $display("golden file line after test %0d is malformed", tests_run);
               errors++;
               done = 1'b1;
            end
            else
            begin
               run_golden_line();
               done = timed_out;
            end
         end
      end
      if (fd != 0)
         $fclose(fd);
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0 && tests_run > 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

//--- source/apb_soc_ctrl.sv
`timescale 1ns/1ps
`include "soc_ctrl_consts.svh"

module apb_soc_ctrl
(
   input  logic                                     HCLK,
   input  logic                                     HRESETn,
   input  soc_ctrl_pkg::apb_addr_t                  paddr_i,
   input  soc_ctrl_pkg::reg_word_t                  pwdata_i,
   input  logic                                     pwrite_i,
   input  logic                                     psel_i,
   input  logic                                     penable_i,
   output soc_ctrl_pkg::reg_word_t                  prdata_o,
   output logic                                     pready_o,
   output logic                                     pslverr_o,

   input  logic                                     sel_fll_clk_i,
   input  logic [1:0]                               bootsel_i,
   input  logic                                     fc_fetch_en_valid_i,
   input  logic                                     fc_fetch_en_i,
   input  soc_ctrl_pkg::jtag_word_t                 soc_jtag_reg_i,

   output soc_ctrl_pkg::pad_cfg_t [`NUM_PADS-1:0]   pad_cfg_o,
   output soc_ctrl_pkg::pad_fun_t [`NUM_PADS-1:0]   pad_mux_o,
   output soc_ctrl_pkg::jtag_word_t                 soc_jtag_reg_o,
   output soc_ctrl_pkg::reg_word_t                  fc_bootaddr_o,
   output logic                                     fc_fetchen_o,
   output logic                                     cluster_pow_o,
   output logic                                     cluster_byp_o,
   output logic [63:0]                              cluster_boot_addr_o,
   output logic                                     cluster_fetch_enable_o,
   output logic                                     cluster_rstn_o,
   output logic                                     cluster_irq_o
);

   soc_ctrl_pkg::reg_wr_t       reg_wr;
   soc_ctrl_pkg::reg_index_t    rd_index;
   soc_ctrl_pkg::reg_word_t     pad_rdata;
   soc_ctrl_pkg::reg_word_t     boot_rdata;
   soc_ctrl_pkg::reg_word_t     cluster_rdata;
   soc_ctrl_pkg::reg_word_t     jtag_rdata;
   soc_ctrl_pkg::cluster_ctrl_t cluster_ctrl;

   // write lands on the edge that closes the access phase
   assign reg_wr.wr_en = psel_i & penable_i & pwrite_i;
   assign reg_wr.index = paddr_i[8:2];
   assign reg_wr.wdata = pwdata_i;
   assign rd_index     = paddr_i[8:2];

   pad_ctrl_regs pad_ctrl_regs_i
   (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .wr_i       (reg_wr),
      .rd_index_i (rd_index),
      .rdata_o    (pad_rdata),
      .pad_mux_o  (pad_mux_o),
      .pad_cfg_o  (pad_cfg_o)
   );

   boot_status_regs boot_status_regs_i
   (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .wr_i                (reg_wr),
      .rd_index_i          (rd_index),
      .bootsel_i           (bootsel_i),
      .sel_fll_clk_i       (sel_fll_clk_i),
      .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
      .fc_fetch_en_i       (fc_fetch_en_i),
      .rdata_o             (boot_rdata),
      .fc_bootaddr_o       (fc_bootaddr_o),
      .fc_fetchen_o        (fc_fetchen_o)
   );

   cluster_ctrl_regs cluster_ctrl_regs_i
   (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .wr_i                (reg_wr),
      .rd_index_i          (rd_index),
      .rdata_o             (cluster_rdata),
      .cluster_ctrl_o      (cluster_ctrl),
      .cluster_irq_o       (cluster_irq_o),
      .cluster_boot_addr_o (cluster_boot_addr_o)
   );

   jtag_mailbox jtag_mailbox_i
   (
      .HCLK           (HCLK),
      .HRESETn        (HRESETn),
      .wr_i           (reg_wr),
      .rd_index_i     (rd_index),
      .soc_jtag_reg_i (soc_jtag_reg_i),
      .rdata_o        (jtag_rdata),
      .soc_jtag_reg_o (soc_jtag_reg_o)
   );

   assign cluster_byp_o          = cluster_ctrl.byp;
   assign cluster_pow_o          = cluster_ctrl.pow;
   assign cluster_fetch_enable_o = cluster_ctrl.fetch_en;
   assign cluster_rstn_o         = cluster_ctrl.rstn;

   // blocks return zero outside their own indices
   assign prdata_o  = pad_rdata | boot_rdata | cluster_rdata | jtag_rdata;

   assign pready_o  = 1'b1;  // zero wait states
   assign pslverr_o = 1'b0;

endmodule

//--- source/jtag_mailbox.sv
`timescale 1ns/1ps
`include "soc_ctrl_consts.svh"

module jtag_mailbox
(
   input  logic                       HCLK,
   input  logic                       HRESETn,
   input  soc_ctrl_pkg::reg_wr_t      wr_i,
   input  soc_ctrl_pkg::reg_index_t   rd_index_i,
   input  soc_ctrl_pkg::jtag_word_t   soc_jtag_reg_i,
   output soc_ctrl_pkg::reg_word_t    rdata_o,
   output soc_ctrl_pkg::jtag_word_t   soc_jtag_reg_o
);

   soc_ctrl_pkg::jtag_word_t jtag_out_q;
   soc_ctrl_pkg::jtag_word_t jtag_in_meta_q;  // first sync stage
   soc_ctrl_pkg::jtag_word_t jtag_in_q;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         jtag_out_q     <= '0;
         jtag_in_meta_q <= '0;
         jtag_in_q      <= '0;
      end
      else
      begin
         jtag_in_meta_q <= soc_jtag_reg_i;  // jtag side is asynchronous
         jtag_in_q      <= jtag_in_meta_q;
         if (wr_i.wr_en && wr_i.index == `REG_JTAGREG)
         begin
            jtag_out_q <= wr_i.wdata[`JTAG_REG_WIDTH-1:0];
         end
      end
   end

   assign rdata_o = (rd_index_i == `REG_JTAGREG) ? {16'h0, jtag_in_q, jtag_out_q} : '0;

   assign soc_jtag_reg_o = jtag_out_q;

endmodule

//--- source/cluster_ctrl_regs.sv
`timescale 1ns/1ps
`include "soc_ctrl_consts.svh"

module cluster_ctrl_regs
(
   input  logic                         HCLK,
   input  logic                         HRESETn,
   input  soc_ctrl_pkg::reg_wr_t        wr_i,
   input  soc_ctrl_pkg::reg_index_t     rd_index_i,
   output soc_ctrl_pkg::reg_word_t      rdata_o,
   output soc_ctrl_pkg::cluster_ctrl_t  cluster_ctrl_o,
   output logic                         cluster_irq_o,
   output logic [63:0]                  cluster_boot_addr_o
);

   soc_ctrl_pkg::cluster_ctrl_t ctrl_q;
   logic                        irq_q;
   logic [63:0]                 boot_addr_q;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         ctrl_q      <= '{rstn: 1'b1, fetch_en: 1'b0, pow: 1'b0, byp: 1'b1};
         irq_q       <= 1'b0;
         boot_addr_q <= '0;
      end
      else if (wr_i.wr_en)
      begin
         case (wr_i.index)
            `REG_CLUSTER_CTRL:       ctrl_q <= soc_ctrl_pkg::cluster_ctrl_t'(wr_i.wdata[3:0]);
            `REG_CLUSTER_IRQ:        irq_q  <= wr_i.wdata[0];
            `REG_CLUSTER_BOOT_ADDR0: boot_addr_q[31:0]  <= wr_i.wdata;
            `REG_CLUSTER_BOOT_ADDR1: boot_addr_q[63:32] <= wr_i.wdata;
            default:
            begin
               // not a cluster register
            end
         endcase
      end
   end

   always_comb
   begin
      case (rd_index_i)
         `REG_CLUSTER_CTRL:       rdata_o = {28'h0, ctrl_q};
         `REG_CLUSTER_IRQ:        rdata_o = {31'h0, irq_q};
         `REG_CLUSTER_BOOT_ADDR0: rdata_o = boot_addr_q[31:0];
         `REG_CLUSTER_BOOT_ADDR1: rdata_o = boot_addr_q[63:32];
         default:                 rdata_o = '0;
      endcase
   end

   assign cluster_ctrl_o      = ctrl_q;
   assign cluster_irq_o       = irq_q;
   assign cluster_boot_addr_o = boot_addr_q;

endmodule

//--- source/boot_status_regs.sv
`timescale 1ns/1ps
`include "soc_ctrl_consts.svh"

module boot_status_regs
(
   input  logic                      HCLK,
   input  logic                      HRESETn,
   input  soc_ctrl_pkg::reg_wr_t     wr_i,
   input  soc_ctrl_pkg::reg_index_t  rd_index_i,
   input  logic [1:0]                bootsel_i,
   input  logic                      sel_fll_clk_i,
   input  logic                      fc_fetch_en_valid_i,
   input  logic                      fc_fetch_en_i,
   output soc_ctrl_pkg::reg_word_t   rdata_o,
   output soc_ctrl_pkg::reg_word_t   fc_bootaddr_o,
   output logic                      fc_fetchen_o
);

   soc_ctrl_pkg::reg_word_t bootaddr_q;
   soc_ctrl_pkg::reg_word_t corestatus_q;  // eoc in bit 31, status below
   logic                    fetchen_q;
   logic [1:0]              bootsel_q;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         bootaddr_q   <= `FC_BOOT_RESET;
         corestatus_q <= '0;
         fetchen_q    <= 1'b0;  // fc stays idle out of reset
         bootsel_q    <= 2'b00;
      end
      else
      begin
         bootsel_q <= bootsel_i;
         if (wr_i.wr_en && wr_i.index == `REG_FCBOOT)
         begin
            bootaddr_q <= wr_i.wdata;
         end
         if (wr_i.wr_en && wr_i.index == `REG_CORESTATUS)
         begin
            corestatus_q <= wr_i.wdata;
         end
         // the APB write takes priority over the external override
         if (wr_i.wr_en && wr_i.index == `REG_FCFETCH)
         begin
            fetchen_q <= wr_i.wdata[0];
         end
         else if (fc_fetch_en_valid_i)
         begin
            fetchen_q <= fc_fetch_en_i;
         end
      end
   end

   always_comb
   begin
      case (rd_index_i)
         `REG_FCBOOT:     rdata_o = bootaddr_q;
         `REG_INFO:       rdata_o = {16'(`NB_CORES), 16'(`NB_CLUSTERS)};
         `REG_CORESTATUS: rdata_o = corestatus_q;
         `REG_CS_RO:      rdata_o = corestatus_q;  // read only mirror
         `REG_BOOTSEL:    rdata_o = {30'h0, bootsel_q};
         `REG_CLKSEL:     rdata_o = {31'h0, sel_fll_clk_i};
         default:         rdata_o = '0;  // FCFETCH included
      endcase
   end

   assign fc_bootaddr_o = bootaddr_q;
   assign fc_fetchen_o  = fetchen_q;

endmodule

//--- source/pad_ctrl_regs.sv
`timescale 1ns/1ps
`include "soc_ctrl_consts.svh"

module pad_ctrl_regs
(
   input  logic                                         HCLK,
   input  logic                                         HRESETn,
   input  soc_ctrl_pkg::reg_wr_t                        wr_i,
   input  soc_ctrl_pkg::reg_index_t                     rd_index_i,
   output soc_ctrl_pkg::reg_word_t                      rdata_o,
   output soc_ctrl_pkg::pad_fun_t [`NUM_PADS-1:0]       pad_mux_o,
   output soc_ctrl_pkg::pad_cfg_t [`NUM_PADS-1:0]       pad_cfg_o
);

   localparam int FUN_BITS  = $bits(soc_ctrl_pkg::pad_fun_t);
   localparam int LANE_BITS = 32 / `PADS_PER_CFG_WORD;          // one byte lane per pad
   localparam int FUN_WORDS = `NUM_PADS / `PADS_PER_FUN_WORD;
   localparam int CFG_WORDS = `NUM_PADS / `PADS_PER_CFG_WORD;

   soc_ctrl_pkg::pad_fun_t [`NUM_PADS-1:0] pad_fun_q;
   soc_ctrl_pkg::pad_cfg_t [`NUM_PADS-1:0] pad_cfg_q;

   soc_ctrl_pkg::reg_index_t wr_fun_ofs;
   soc_ctrl_pkg::reg_index_t wr_cfg_ofs;
   soc_ctrl_pkg::reg_index_t rd_fun_ofs;
   soc_ctrl_pkg::reg_index_t rd_cfg_ofs;

   // below the base the offset wraps high, so one compare covers the range
   assign wr_fun_ofs = wr_i.index - `REG_PADFUN0;
   assign wr_cfg_ofs = wr_i.index - `REG_PADCFG0;
   assign rd_fun_ofs = rd_index_i - `REG_PADFUN0;
   assign rd_cfg_ofs = rd_index_i - `REG_PADCFG0;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         pad_fun_q <= '0;
         pad_cfg_q <= {`NUM_PADS{`PADCFG_RESET}};
      end
      else if (wr_i.wr_en)
      begin
         for (int p = 0; p < `NUM_PADS; p++)
         begin
            if (int'(wr_fun_ofs) < FUN_WORDS && p / `PADS_PER_FUN_WORD == int'(wr_fun_ofs))
            begin
               pad_fun_q[p] <= wr_i.wdata[FUN_BITS*(p % `PADS_PER_FUN_WORD) +: FUN_BITS];
            end
            if (int'(wr_cfg_ofs) < CFG_WORDS && p / `PADS_PER_CFG_WORD == int'(wr_cfg_ofs))
            begin
               pad_cfg_q[p] <= wr_i.wdata[LANE_BITS*(p % `PADS_PER_CFG_WORD) +: `PADCFG_WIDTH];
            end
         end
      end
   end

   always_comb
   begin
      rdata_o = '0;
      if (int'(rd_fun_ofs) < FUN_WORDS)
      begin
         for (int i = 0; i < `PADS_PER_FUN_WORD; i++)
         begin
            rdata_o[FUN_BITS*i +: FUN_BITS] =
               pad_fun_q[int'(rd_fun_ofs) * `PADS_PER_FUN_WORD + i];
         end
      end
      else if (int'(rd_cfg_ofs) < CFG_WORDS)
      begin
         for (int i = 0; i < `PADS_PER_CFG_WORD; i++)
         begin
            rdata_o[LANE_BITS*i +: `PADCFG_WIDTH] =
               pad_cfg_q[int'(rd_cfg_ofs) * `PADS_PER_CFG_WORD + i];  // bits 7..6 stay zero
         end
      end
   end

   assign pad_mux_o = pad_fun_q;
   assign pad_cfg_o = pad_cfg_q;

endmodule

//--- source/soc_ctrl_pkg.sv
`include "soc_ctrl_consts.svh"

package soc_ctrl_pkg;

   typedef logic [31:0]                    reg_word_t;
   typedef logic [6:0]                     reg_index_t;  // word index, byte addr bits 8..2
   typedef logic [`APB_ADDR_WIDTH-1:0]     apb_addr_t;
   typedef logic [1:0]                     pad_fun_t;    // pad mux select

   // bit 0 pull up, bit 1 pull down, bit 2 schmitt trigger,
   // bit 3 slew limit, bits 5..4 drive strength
   typedef logic [`PADCFG_WIDTH-1:0]       pad_cfg_t;

   typedef logic [`JTAG_REG_WIDTH-1:0]     jtag_word_t;

   typedef struct packed {
      logic       wr_en;   // access phase of an APB write
      reg_index_t index;
      reg_word_t  wdata;
   } reg_wr_t;

   // same layout as CLUSTER_CTRL bits 3..0
   typedef struct packed {
      logic rstn;
      logic fetch_en;
      logic pow;
      logic byp;
   } cluster_ctrl_t;

endpackage

//--- source/soc_ctrl_consts.svh
`ifndef SOC_CTRL_CONSTS_SVH
`define SOC_CTRL_CONSTS_SVH

// register word indices, byte address bits 8..2
`define REG_INFO               7'b0000000
`define REG_FCBOOT             7'b0000001
`define REG_FCFETCH            7'b0000010
`define REG_PADFUN0            7'b0000100 // four words follow
`define REG_PADCFG0            7'b0001000 // sixteen words follow
`define REG_CLUSTER_CTRL       7'b0011100
`define REG_JTAGREG            7'b0011101
`define REG_CLUSTER_IRQ        7'b0011111
`define REG_CLUSTER_BOOT_ADDR0 7'b0100000
`define REG_CLUSTER_BOOT_ADDR1 7'b0100001
`define REG_CORESTATUS         7'b0101000
`define REG_CS_RO              7'b0110000
`define REG_BOOTSEL            7'b0110001
`define REG_CLKSEL             7'b0110010

`define NUM_PADS               64
`define PADS_PER_FUN_WORD      16
`define PADS_PER_CFG_WORD      4
`define NB_CORES               4
`define NB_CLUSTERS            1

`define APB_ADDR_WIDTH         12
`define PADCFG_WIDTH           6
`define JTAG_REG_WIDTH         8

`define FC_BOOT_RESET          32'h1A000080
`define PADCFG_RESET           6'h3F

`endif
